// File: common/apb_reg_pkg.sv
// *************************************************
// Shared widths, types, register map constants and
// the APB front-end state encoding
// *************************************************

package apb_reg_pkg;

    // APB bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int PROT_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [PROT_WIDTH-1:0] prot_t;

    // Register map, word registers at 0x00 to 0x1C
    localparam int NUM_REGS      = 8;
    localparam int REG_IDX_WIDTH = 3;
    localparam int PRIV_REG      = 7;
    localparam data_t ID_VALUE   = 32'hA9B0_0101;

    // Skid buffer sizing
    localparam int SKID_DEPTH     = 2;
    localparam int SKID_PTR_WIDTH = (SKID_DEPTH > 1) ? $clog2(SKID_DEPTH) : 1;
    localparam int SKID_CNT_WIDTH = $clog2(SKID_DEPTH + 1);

    // Packed packets: {pwrite, pprot, pstrb, paddr, pwdata} and {pslverr, prdata}
    localparam int CMD_PKT_WIDTH = 1 + PROT_WIDTH + STRB_WIDTH + ADDR_WIDTH + DATA_WIDTH;
    localparam int RSP_PKT_WIDTH = 1 + DATA_WIDTH;

    // Front-end FSM, one-hot
    typedef enum logic [2:0] {
        IDLE = 3'b001,
        BUSY = 3'b010,
        WAIT = 3'b100
    } apb_state_t;

endpackage

// File: common/apb_cmd_if.sv
// *************************************************
// Command packet channel, front end to register bank
// *************************************************

`timescale 1ns/1ps

interface apb_cmd_if import apb_reg_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    strb_t pstrb;
    prot_t pprot;

    // Front end side
    modport source (
        output valid, pwrite, paddr, pwdata, pstrb, pprot,
        input  ready
    );

    // Register bank side
    modport sink (
        input  valid, pwrite, paddr, pwdata, pstrb, pprot,
        output ready
    );

endinterface

// File: common/apb_rsp_if.sv
// *************************************************
// Response packet channel, register bank to front end
// *************************************************

`timescale 1ns/1ps

interface apb_rsp_if import apb_reg_pkg::*; ();

    logic  valid;
    logic  ready;
    data_t prdata;
    logic  pslverr;

    modport source (
        output valid, prdata, pslverr,
        input  ready
    );

    modport sink (
        input  valid, prdata, pslverr,
        output ready
    );

endinterface

// File: hw/skid_buffer.sv
// *************************************************
// Small circular valid/ready FIFO for packed words
// *************************************************

`timescale 1ns/1ps

module skid_buffer import apb_reg_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic [DATA_WIDTH-1:0] rd_data
);

    logic [DATA_WIDTH-1:0]     mem [SKID_DEPTH];
    logic [SKID_PTR_WIDTH-1:0] wr_ptr;
    logic [SKID_PTR_WIDTH-1:0] rd_ptr;
    logic [SKID_CNT_WIDTH-1:0] count;
    logic                      wr_fire;
    logic                      rd_fire;

    function automatic logic [SKID_PTR_WIDTH-1:0] next_ptr(
        input logic [SKID_PTR_WIDTH-1:0] ptr
    );
        if (ptr == SKID_PTR_WIDTH'(SKID_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_ready = (count != SKID_CNT_WIDTH'(SKID_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    // Storage
    always_ff @(posedge pclk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: apb_slave/apb_slave.sv
// *************************************************
// APB completer front end with command and response
// skid buffers around a three-state transfer FSM
// *************************************************

`timescale 1ns/1ps

module apb_slave import apb_reg_pkg::*; (
    input  logic   pclk,
    input  logic   rst,

    // APB completer port
    input  logic   psel,
    input  logic   penable,
    input  addr_t  paddr,
    input  logic   pwrite,
    input  data_t  pwdata,
    input  strb_t  pstrb,
    input  prot_t  pprot,
    output logic   pready,
    output data_t  prdata,
    output logic   pslverr,

    // Backend channels
    apb_cmd_if.source cmd,
    apb_rsp_if.sink   rsp
);

    logic                     cmd_wr_valid;
    logic                     cmd_wr_ready;
    logic [CMD_PKT_WIDTH-1:0] cmd_wr_data;
    logic [CMD_PKT_WIDTH-1:0] cmd_rd_data;

    logic                     rsp_rd_valid;
    logic                     rsp_rd_ready;
    logic [RSP_PKT_WIDTH-1:0] rsp_wr_data;
    data_t                    rsp_prdata;
    logic                     rsp_pslverr;

    apb_state_t state;
    logic       penable_d;

    // Command path
    assign cmd_wr_data = {pwrite, pprot, pstrb, paddr, pwdata};
    assign {cmd.pwrite, cmd.pprot, cmd.pstrb, cmd.paddr, cmd.pwdata} = cmd_rd_data;

    skid_buffer #(
        .DATA_WIDTH (CMD_PKT_WIDTH)
    ) u_cmd_skid (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (cmd_wr_valid),
        .wr_ready (cmd_wr_ready),
        .wr_data  (cmd_wr_data),
        .rd_valid (cmd.valid),
        .rd_ready (cmd.ready),
        .rd_data  (cmd_rd_data)
    );

    // Response path
    assign rsp_wr_data = {rsp.pslverr, rsp.prdata};

    skid_buffer #(
        .DATA_WIDTH (RSP_PKT_WIDTH)
    ) u_rsp_skid (
        .pclk     (pclk),
        .rst      (rst),
        .wr_valid (rsp.valid),
        .wr_ready (rsp.ready),
        .wr_data  (rsp_wr_data),
        .rd_valid (rsp_rd_valid),
        .rd_ready (rsp_rd_ready),
        .rd_data  ({rsp_pslverr, rsp_prdata})
    );

    always_ff @(posedge pclk) begin
        if (rst) begin
            state        <= IDLE;
            penable_d    <= 1'b0;
            cmd_wr_valid <= 1'b0;
            rsp_rd_ready <= 1'b0;
            pready       <= 1'b0;
            pslverr      <= 1'b0;
            prdata       <= '0;
        end else begin
            penable_d    <= penable;
            cmd_wr_valid <= 1'b0;
            rsp_rd_ready <= 1'b0;
            pready       <= 1'b0;
            pslverr      <= 1'b0;
            case (state)
                IDLE: begin
                    // Capture once per access phase, on the penable rising edge
                    if (psel && penable && !penable_d && cmd_wr_ready) begin
                        cmd_wr_valid <= 1'b1;
                        state        <= BUSY;
                    end
                end
                BUSY: begin
                    if (rsp_rd_valid) begin
                        pready       <= 1'b1;
                        prdata       <= rsp_prdata;
                        pslverr      <= rsp_pslverr;
                        rsp_rd_ready <= 1'b1;
                        state        <= WAIT;
                    end
                end
                // Response pops here while the master drops psel
                WAIT:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/reg_bank.sv
// *************************************************
// Eight-word register file with byte strobes,
// protection and address checks
// *************************************************

`timescale 1ns/1ps

module reg_bank import apb_reg_pkg::*; (
    input  logic    pclk,
    input  logic    rst,
    apb_cmd_if.sink cmd,
    apb_rsp_if.source rsp
);

    data_t                    regs [1:NUM_REGS-1];
    logic [REG_IDX_WIDTH-1:0] reg_idx;
    logic                     addr_ok;
    logic                     err;
    logic                     cmd_fire;
    logic                     wr_en;
    data_t                    rd_word;
    logic                     rsp_valid_q;

    // One response slot, freed on the edge it is taken
    assign cmd.ready = !rsp_valid_q || rsp.ready;
    assign cmd_fire  = cmd.valid && cmd.ready;
    assign rsp.valid = rsp_valid_q;

    // Word index from the address, low two bits ignored
    assign reg_idx = cmd.paddr[REG_IDX_WIDTH+1:2];
    assign addr_ok = (cmd.paddr < addr_t'(NUM_REGS * 4));

    assign err = !addr_ok
              || (cmd.pwrite && (reg_idx == '0))
              || (cmd.pwrite && (reg_idx == REG_IDX_WIDTH'(PRIV_REG)) && !cmd.pprot[0]);

    assign wr_en = cmd_fire && cmd.pwrite && !err;

    always_comb begin
        if (reg_idx == '0) begin
            rd_word = ID_VALUE;
        end else begin
            rd_word = regs[reg_idx];
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (cmd_fire) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp.ready) begin
                rsp_valid_q <= 1'b0;
            end
            // Byte merge under strobes
            if (wr_en) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (cmd.pstrb[b]) begin
                        regs[reg_idx][8*b +: 8] <= cmd.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Response payload, zero data on errors and writes
    always_ff @(posedge pclk) begin
        if (cmd_fire) begin
            rsp.prdata  <= (err || cmd.pwrite) ? '0 : rd_word;
            rsp.pslverr <= err;
        end
    end

endmodule

// File: hw/apb_reg_top.sv
// *************************************************
// APB register subsystem top level
// *************************************************

`timescale 1ns/1ps

module apb_reg_top import apb_reg_pkg::*; (
    input  logic  pclk,
    input  logic  rst,
    input  logic  psel,
    input  logic  penable,
    input  addr_t paddr,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    input  prot_t pprot,
    output logic  pready,
    output data_t prdata,
    output logic  pslverr
);

    apb_cmd_if cmd_bus ();
    apb_rsp_if rsp_bus ();

    apb_slave u_apb_slave (
        .pclk    (pclk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pprot   (pprot),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .cmd     (cmd_bus.source),
        .rsp     (rsp_bus.sink)
    );

    reg_bank u_reg_bank (
        .pclk (pclk),
        .rst  (rst),
        .cmd  (cmd_bus.sink),
        .rsp  (rsp_bus.source)
    );

endmodule

// File: test/tb_apb_reg_top.sv
// *************************************************
// Directed testbench for the APB register subsystem
// with an APB master task set and a register model
// *************************************************

`timescale 1ns/1ps

module tb_apb_reg_top import apb_reg_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int MAX_WAIT      = 20;
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_TRANSFERS = 40 + NUM_RANDOM;

    logic  pclk = 1'b0;
    logic  rst;
    logic  psel;
    logic  penable;
    addr_t paddr;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
    prot_t pprot;
    logic  pready;
    data_t prdata;
    logic  pslverr;

    data_t model [NUM_REGS];
    int    seed = 98;

    apb_reg_top u_dut (
        .pclk    (pclk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pprot   (pprot),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    task automatic check_value(input data_t actual, input data_t expected, input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Access phase until pready, then one idle cycle with psel low
    task automatic finish_transfer(output logic err, output data_t data);
        int waited;
        waited  = 0;
        penable = 1'b1;
        while (!pready) begin
            if (waited == MAX_WAIT) begin
                $display("ERROR: pready did not arrive within %0d cycles at %0t", MAX_WAIT, $time);
                $display("Test failed");
                $fatal(1);
            end else begin
                @(posedge pclk);
                #1;
                waited++;
            end
        end
        err     = pslverr;
        data    = prdata;
        // Transfer completes on the edge that samples pready high
        @(posedge pclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        @(posedge pclk);
        #1;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data, input strb_t strb,
                             input prot_t prot, output logic err);
        data_t rsp_data;
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        pstrb   = strb;
        pprot   = prot;
        @(posedge pclk);
        #1;
        finish_transfer(err, rsp_data);
        // Write responses carry no data
        check_value(rsp_data, '0, $sformatf("write response data @%h", addr));
    endtask

    task automatic apb_read(input addr_t addr, input prot_t prot,
                            output data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = 1'b0;
        pstrb   = '0;
        pprot   = prot;
        @(posedge pclk);
        #1;
        finish_transfer(err, data);
    endtask

    // Expected response from the register map rules, model updated on good writes
    task automatic predict(input logic write, input addr_t addr, input data_t wdata,
                           input strb_t strb, input prot_t prot,
                           output logic exp_err, output data_t exp_data);
        int idx;
        idx      = int'(addr[4:2]);
        exp_err  = (addr >= 32'h20) || (write && idx == 0)
                || (write && idx == PRIV_REG && !prot[0]);
        exp_data = '0;
        if (!exp_err && write) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    model[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!exp_err) begin
            exp_data = model[idx];
        end
    endtask

    task automatic checked_access(input logic write, input addr_t addr, input data_t wdata,
                                  input strb_t strb, input prot_t prot, input string msg);
        logic  exp_err;
        data_t exp_data;
        logic  got_err;
        data_t got_data;
        predict(write, addr, wdata, strb, prot, exp_err, exp_data);
        if (write) begin
            apb_write(addr, wdata, strb, prot, got_err);
        end else begin
            apb_read(addr, prot, got_data, got_err);
            check_value(got_data, exp_data, $sformatf("%s read data @%h", msg, addr));
        end
        check_value(32'(got_err), 32'(exp_err), $sformatf("%s pslverr @%h", msg, addr));
    endtask

    task automatic readback_all(input string msg);
        for (int i = 0; i < NUM_REGS; i++) begin
            checked_access(1'b0, addr_t'(i * 4), '0, '0, '0, msg);
        end
    endtask

    task automatic test_reset_state();
        readback_all("reset state");
    endtask

    task automatic test_full_word();
        for (int i = 1; i < NUM_REGS - 1; i++) begin
            checked_access(1'b1, addr_t'(i * 4), data_t'(32'hC0DE_0000 + i * 32'h1111), 4'hF,
                           3'b000, "full word write");
        end
        for (int i = 1; i < NUM_REGS - 1; i++) begin
            checked_access(1'b0, addr_t'(i * 4), '0, '0, '0, "full word readback");
        end
    endtask

    task automatic test_byte_strobes();
        checked_access(1'b1, 32'h08, 32'hFFFF_FFFF, 4'b0001, 3'b000, "strobe write");
        checked_access(1'b0, 32'h08, '0, '0, '0, "strobe readback");
        checked_access(1'b1, 32'h0C, 32'hAABB_CCDD, 4'b1010, 3'b000, "strobe write");
        checked_access(1'b0, 32'h0C, '0, '0, '0, "strobe readback");
        checked_access(1'b1, 32'h10, 32'h1357_9BDF, 4'b0110, 3'b000, "strobe write");
        checked_access(1'b0, 32'h10, '0, '0, '0, "strobe readback");
    endtask

    // Out of range, read-only ID and unprivileged access to the protected word
    task automatic test_errors();
        checked_access(1'b0, 32'h20, '0, '0, '0, "read out of range");
        checked_access(1'b1, 32'h24, 32'hDEAD_BEEF, 4'hF, 3'b001, "write out of range");
        checked_access(1'b1, 32'h00, 32'h0BAD_0BAD, 4'hF, 3'b001, "write to ID");
        checked_access(1'b1, 32'h1C, 32'h5555_AAAA, 4'hF, 3'b010, "unprivileged write");
        readback_all("after errors");
    endtask

    task automatic test_privilege();
        checked_access(1'b1, 32'h1C, 32'h7E57_F00D, 4'hF, 3'b001, "privileged write");
        checked_access(1'b0, 32'h1C, '0, '0, '0, "privileged readback");
    endtask

    task automatic test_random_traffic();
        logic [31:0] ctl;
        data_t       wdata;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            ctl   = $random(seed);
            wdata = $random(seed);
            checked_access(ctl[4], {26'b0, ctl[3:0] % 4'd10, 2'b00}, wdata, ctl[8:5],
                           ctl[11:9], "random traffic");
        end
    endtask

    // Watchdog sized from the number of transfers
    initial begin
        #(CLK_PERIOD * (NUM_TRANSFERS * 30 + 100));
        $display("ERROR: simulation watchdog expired at %0t", $time);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        paddr   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        pprot   = '0;
        model[0] = ID_VALUE;
        for (int i = 1; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge pclk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_full_word();
        test_byte_strobes();
        test_errors();
        test_privilege();
        test_random_traffic();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: apb_reg.f
common/apb_reg_pkg.sv
common/apb_cmd_if.sv
common/apb_rsp_if.sv
hw/skid_buffer.sv
apb_slave/apb_slave.sv
hw/reg_bank.sv
hw/apb_reg_top.sv
test/tb_apb_reg_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the APB register testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_apb_reg_top \
    -f apb_reg.f \
    -o tb_apb_reg_top

./obj_dir/tb_apb_reg_top
